//--- common/tex_cfg_pkg.sv
`default_nettype none

package tex_cfg_pkg;

    localparam int NUM_LANES  = 4;
    localparam int NUM_TEXELS = 4;
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    // word address drops the byte offset bits
    localparam int WADDR_W    = ADDR_W - 2;

    localparam int BANK_WORDS = 256;
    localparam int BANK_AW    = 8;
    // output queue slots, also the credits per bank
    localparam int BANK_DEPTH = 4;
    localparam int BANKQ_PW   = $clog2(BANK_DEPTH);
    localparam int CREDIT_W   = $clog2(BANK_DEPTH + 1);

    localparam int REQQ_DEPTH = 2;
    localparam int REQQ_PW    = $clog2(REQQ_DEPTH);
    localparam int REQQ_CW    = $clog2(REQQ_DEPTH + 1);

    localparam int INFO_W     = 8;
    // 0 byte, 1 halfword, 2 word
    localparam int LGSTRIDE_W = 2;
    localparam int TIDX_W     = 2;

endpackage

`default_nettype wire

//--- common/tex_types_pkg.sv
`default_nettype none

package tex_types_pkg;
    import tex_cfg_pkg::*;

    // same returned word, picked apart by texel size
    typedef union packed {
        logic [DATA_W-1:0] word;
        logic [3:0][7:0]   bytes;
        logic [1:0][15:0]  halves;
    } texel_word_u;

    // one request as it sits in the request queue
    typedef struct packed {
        logic [NUM_TEXELS-1:0][NUM_LANES-1:0][WADDR_W-1:0] waddr;
        logic [NUM_TEXELS-1:0][NUM_LANES-1:0][1:0]         boff;
        logic [NUM_LANES-1:0]                              tmask;
        logic                                              filter;
        logic [LGSTRIDE_W-1:0]                             lgstride;
        logic [NUM_TEXELS-1:0]                             dup;
        logic [INFO_W-1:0]                                 info;
    } tex_req_t;

endpackage

`default_nettype wire

//--- common/tex_bank_req_if.sv
`timescale 1ns/1ns
`default_nettype none

interface tex_bank_req_if;
    import tex_cfg_pkg::*;

    // no ready, issue only raises valid while it holds a credit
    logic [NUM_LANES-1:0]              valid;
    logic [NUM_LANES-1:0][WADDR_W-1:0] addr;
    logic [TIDX_W-1:0]                 tidx;

    modport issue (
        output valid, addr, tidx
    );

    modport bank (
        input valid, addr, tidx
    );

endinterface

`default_nettype wire

//--- common/tex_bank_rsp_if.sv
`timescale 1ns/1ns
`default_nettype none

interface tex_bank_rsp_if;
    import tex_cfg_pkg::*;

    // each bank drives its own lane
    wire [NUM_LANES-1:0]             valid;
    wire [NUM_LANES-1:0][DATA_W-1:0] data;
    wire [NUM_LANES-1:0][TIDX_W-1:0] tidx;
    // pop drains the head and hands a credit back to issue
    logic [NUM_LANES-1:0]            pop;

    modport bank (output valid, data, tidx, input pop);

    modport merge (input valid, data, tidx, output pop);

    modport credit (input pop);

endinterface

`default_nettype wire

//--- src/tex_mem_bank.sv
`timescale 1ns/1ns
`default_nettype none

module tex_mem_bank #(
    parameter int LANE = 0
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              load_valid,
    input  wire [tex_cfg_pkg::BANK_AW-1:0]   load_addr,
    input  wire [tex_cfg_pkg::DATA_W-1:0]    load_data,
    tex_bank_req_if.bank                     req,
    tex_bank_rsp_if.bank                     rsp
);
    import tex_cfg_pkg::*;

    logic [DATA_W-1:0]   mem [BANK_WORDS];
    logic                rd_valid;
    logic [DATA_W-1:0]   rd_data;
    logic [TIDX_W-1:0]   rd_tidx;

    logic [DATA_W-1:0]   q_data [BANK_DEPTH];
    logic [TIDX_W-1:0]   q_tidx [BANK_DEPTH];
    logic [BANKQ_PW-1:0] wr_ptr;
    logic [BANKQ_PW-1:0] rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic                pop;

    // load port is broadcast to every copy
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr] <= load_data;
        end
        rd_data <= mem[req.addr[LANE][BANK_AW-1:0]];
        rd_tidx <= req.tidx;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.valid[LANE];
        end
    end

    // output queue, credits keep it from overflowing
    assign pop = rsp.pop[LANE] && (count != '0);

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            q_data[wr_ptr] <= rd_data;
            q_tidx[wr_ptr] <= rd_tidx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CREDIT_W'(rd_valid) - CREDIT_W'(pop);
        end
    end

    assign rsp.valid[LANE] = (count != '0);
    assign rsp.data[LANE]  = q_data[rd_ptr];
    assign rsp.tidx[LANE]  = q_tidx[rd_ptr];

endmodule

`default_nettype wire

//--- tex_mem/tex_req_issue.sv
`timescale 1ns/1ns
`default_nettype none

module tex_req_issue (
    input  wire                                            clk,
    input  wire                                            reset,
    input  wire                                            req_valid,
    output logic                                           req_ready,
    input  wire [tex_cfg_pkg::NUM_LANES-1:0]               req_tmask,
    input  wire                                            req_filter,
    input  wire [tex_cfg_pkg::LGSTRIDE_W-1:0]              req_lgstride,
    input  wire [tex_cfg_pkg::NUM_LANES-1:0][tex_cfg_pkg::ADDR_W-1:0] req_baseaddr,
    input  wire [tex_cfg_pkg::NUM_LANES-1:0][tex_cfg_pkg::NUM_TEXELS-1:0]
                [tex_cfg_pkg::ADDR_W-1:0]                  req_addr,
    input  wire [tex_cfg_pkg::INFO_W-1:0]                  req_info,
    tex_bank_req_if.issue                                  bank_req,
    tex_bank_rsp_if.credit                                 bank_rsp,
    output logic                                           head_valid,
    output tex_types_pkg::tex_req_t                        head,
    input  wire                                            head_done
);
    import tex_cfg_pkg::*;
    import tex_types_pkg::*;

    tex_req_t             new_req;
    tex_req_t             reqq [REQQ_DEPTH];
    logic [REQQ_PW-1:0]   wr_ptr;
    logic [REQQ_PW-1:0]   rd_ptr;
    logic [REQQ_CW-1:0]   count;
    logic                 push;

    logic [TIDX_W-1:0]    tidx;
    logic                 texels_done;
    logic [NUM_LANES-1:0] sent_mask;
    logic [NUM_LANES-1:0] need;
    logic [NUM_LANES-1:0] has_credit;
    logic [NUM_LANES-1:0] fire;
    logic                 issue_active;
    logic                 texel_sent;
    logic                 last_sent;
    logic [CREDIT_W-1:0]  credit [NUM_LANES];

    always_comb begin
        logic [ADDR_W-1:0] full;
        for (int t = 0; t < NUM_TEXELS; t++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                full = req_baseaddr[l] + req_addr[l][t];
                new_req.waddr[t][l] = full[ADDR_W-1:2];
                new_req.boff[t][l]  = full[1:0];
            end
        end
        // duplicate when every active lane reads lane 0's word
        for (int t = 0; t < NUM_TEXELS; t++) begin
            new_req.dup[t] = req_tmask[0];
            for (int l = 1; l < NUM_LANES; l++) begin
                if (req_tmask[l] && (new_req.waddr[t][l] != new_req.waddr[t][0])) begin
                    new_req.dup[t] = 1'b0;
                end
            end
        end
        new_req.tmask    = req_tmask;
        new_req.filter   = req_filter;
        new_req.lgstride = req_lgstride;
        new_req.info     = req_info;
    end

    assign push       = req_valid && req_ready;
    assign req_ready  = (count != REQQ_CW'(REQQ_DEPTH));
    assign head_valid = (count != '0);
    assign head       = reqq[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            reqq[wr_ptr] <= new_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head_done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + REQQ_CW'(push) - REQQ_CW'(head_done);
        end
    end

    // texel walk over the queue head
    assign issue_active = head_valid && !texels_done;

    always_comb begin
        need = head.tmask & ~sent_mask;
        if (head.dup[tidx]) begin
            need[NUM_LANES-1:1] = '0;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            has_credit[l] = (credit[l] != '0);
        end
    end

    assign fire       = {NUM_LANES{issue_active}} & need & has_credit;
    assign texel_sent = issue_active && ((need & ~has_credit) == '0);
    assign last_sent  = texel_sent &&
                        (tidx == (head.filter ? TIDX_W'(NUM_TEXELS - 1) : TIDX_W'(0)));

    assign bank_req.valid = fire;
    assign bank_req.addr  = head.waddr[tidx];
    assign bank_req.tidx  = tidx;

    always_ff @(posedge clk) begin
        if (reset) begin
            tidx        <= '0;
            sent_mask   <= '0;
            texels_done <= 1'b0;
        end else begin
            if (texel_sent) begin
                sent_mask <= '0;
                tidx      <= last_sent ? '0 : tidx + 1'b1;
            end else begin
                sent_mask <= sent_mask | fire;
            end
            // hold off until the merger frees the head
            if (head_done) begin
                texels_done <= 1'b0;
            end else if (last_sent) begin
                texels_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (reset) begin
                credit[l] <= CREDIT_W'(BANK_DEPTH);
            end else begin
                credit[l] <= credit[l] - CREDIT_W'(fire[l]) + CREDIT_W'(bank_rsp.pop[l]);
            end
        end
    end

endmodule

`default_nettype wire

//--- tex_mem/tex_rsp_merge.sv
`timescale 1ns/1ns
`default_nettype none

module tex_rsp_merge (
    input  wire                                  clk,
    input  wire                                  reset,
    tex_bank_rsp_if.merge                        bank_rsp,
    input  wire                                  head_valid,
    input  wire tex_types_pkg::tex_req_t         head,
    output logic                                 head_done,
    output logic                                 rsp_valid,
    input  wire                                  rsp_ready,
    output logic [tex_cfg_pkg::NUM_LANES-1:0]    rsp_tmask,
    output logic [tex_cfg_pkg::NUM_LANES-1:0][tex_cfg_pkg::NUM_TEXELS-1:0]
                 [tex_cfg_pkg::DATA_W-1:0]       rsp_data,
    output logic [tex_cfg_pkg::INFO_W-1:0]       rsp_info
);
    import tex_cfg_pkg::*;
    import tex_types_pkg::*;

    logic [TIDX_W-1:0]                                 tidx;
    logic [NUM_LANES-1:0]                              need;
    logic [NUM_LANES-1:0]                              lane_ready;
    logic                                              is_last;
    logic                                              stall_out;
    logic                                              fire;
    logic [NUM_LANES-1:0][DATA_W-1:0]                  texel;
    logic [NUM_LANES-1:0][NUM_TEXELS-1:0][DATA_W-1:0]  acc;

    // a duplicate texel only waits on lane 0
    always_comb begin
        need = head.tmask;
        if (head.dup[tidx]) begin
            need[NUM_LANES-1:1] = '0;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_ready[l] = !need[l] || (bank_rsp.valid[l] && (bank_rsp.tidx[l] == tidx));
        end
    end

    assign is_last   = (tidx == (head.filter ? TIDX_W'(NUM_TEXELS - 1) : TIDX_W'(0)));
    assign stall_out = rsp_valid && !rsp_ready;
    assign fire      = head_valid && (&lane_ready) && !stall_out;
    assign head_done = fire && is_last;

    assign bank_rsp.pop = {NUM_LANES{fire}} & need;

    // realign to the texel size, zero-extended
    always_comb begin
        texel_word_u rdata;
        logic [1:0]  off;
        for (int l = 0; l < NUM_LANES; l++) begin
            rdata.word = head.dup[tidx] ? bank_rsp.data[0] : bank_rsp.data[l];
            off        = head.boff[tidx][l];
            case (head.lgstride)
                LGSTRIDE_W'(0): texel[l] = DATA_W'(rdata.bytes[off]);
                LGSTRIDE_W'(1): texel[l] = DATA_W'(rdata.halves[off[1]]);
                default:        texel[l] = rdata.word;
            endcase
            if (!head.tmask[l]) begin
                texel[l] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tidx <= '0;
        end else if (fire) begin
            tidx <= is_last ? '0 : tidx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                acc[l][tidx] <= texel[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (!stall_out) begin
            rsp_valid <= head_done;
        end
    end

    // last texel bypasses the accumulator
    always_ff @(posedge clk) begin
        if (head_done) begin
            rsp_tmask <= head.tmask;
            rsp_info  <= head.info;
            for (int l = 0; l < NUM_LANES; l++) begin
                for (int t = 0; t < NUM_TEXELS; t++) begin
                    if (TIDX_W'(t) == tidx) begin
                        rsp_data[l][t] <= texel[l];
                    end else if (head.filter) begin
                        rsp_data[l][t] <= acc[l][t];
                    end else begin
                        rsp_data[l][t] <= '0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/tex_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module tex_mem_top (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  load_valid,
    input  wire [tex_cfg_pkg::BANK_AW-1:0]       load_addr,
    input  wire [tex_cfg_pkg::DATA_W-1:0]        load_data,
    input  wire                                  req_valid,
    output wire                                  req_ready,
    input  wire [tex_cfg_pkg::NUM_LANES-1:0]     req_tmask,
    input  wire                                  req_filter,
    input  wire [tex_cfg_pkg::LGSTRIDE_W-1:0]    req_lgstride,
    input  wire [tex_cfg_pkg::NUM_LANES-1:0][tex_cfg_pkg::ADDR_W-1:0] req_baseaddr,
    input  wire [tex_cfg_pkg::NUM_LANES-1:0][tex_cfg_pkg::NUM_TEXELS-1:0]
                [tex_cfg_pkg::ADDR_W-1:0]        req_addr,
    input  wire [tex_cfg_pkg::INFO_W-1:0]        req_info,
    output wire                                  rsp_valid,
    input  wire                                  rsp_ready,
    output wire [tex_cfg_pkg::NUM_LANES-1:0]     rsp_tmask,
    output wire [tex_cfg_pkg::NUM_LANES-1:0][tex_cfg_pkg::NUM_TEXELS-1:0]
                [tex_cfg_pkg::DATA_W-1:0]        rsp_data,
    output wire [tex_cfg_pkg::INFO_W-1:0]        rsp_info
);
    import tex_cfg_pkg::*;
    import tex_types_pkg::*;

    tex_bank_req_if bank_req ();
    tex_bank_rsp_if bank_rsp ();

    logic     head_valid;
    tex_req_t head;
    logic     head_done;

    tex_req_issue u_issue (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_tmask    (req_tmask),
        .req_filter   (req_filter),
        .req_lgstride (req_lgstride),
        .req_baseaddr (req_baseaddr),
        .req_addr     (req_addr),
        .req_info     (req_info),
        .bank_req     (bank_req.issue),
        .bank_rsp     (bank_rsp.credit),
        .head_valid   (head_valid),
        .head         (head),
        .head_done    (head_done)
    );

    // one bank copy per lane
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_bank
        tex_mem_bank #(
            .LANE (l)
        ) u_bank (
            .clk        (clk),
            .reset      (reset),
            .load_valid (load_valid),
            .load_addr  (load_addr),
            .load_data  (load_data),
            .req        (bank_req.bank),
            .rsp        (bank_rsp.bank)
        );
    end

    tex_rsp_merge u_merge (
        .clk        (clk),
        .reset      (reset),
        .bank_rsp   (bank_rsp.merge),
        .head_valid (head_valid),
        .head       (head),
        .head_done  (head_done),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_tmask  (rsp_tmask),
        .rsp_data   (rsp_data),
        .rsp_info   (rsp_info)
    );

endmodule

`default_nettype wire

//--- verification/tex_mem_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module tex_mem_assertions (
    input wire                                  clk,
    input wire                                  reset,
    input wire                                  rsp_valid,
    input wire                                  rsp_ready,
    input wire [tex_cfg_pkg::NUM_LANES-1:0]     rsp_tmask,
    input wire [tex_cfg_pkg::NUM_LANES-1:0][tex_cfg_pkg::NUM_TEXELS-1:0]
               [tex_cfg_pkg::DATA_W-1:0]        rsp_data,
    input wire [tex_cfg_pkg::INFO_W-1:0]        rsp_info
);
    import tex_cfg_pkg::*;

    // a stalled response holds until taken
    property hold_while_stalled;
        @(posedge clk) disable iff (reset)
            (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_tmask) &&
                                           $stable(rsp_data) && $stable(rsp_info));
    endproperty

    a_hold: assert property (hold_while_stalled)
        else $error("response changed while stalled");

    a_reset: assert property (@(posedge clk) reset |=> !rsp_valid)
        else $error("rsp_valid high after reset");

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        a_idle_zero: assert property (@(posedge clk) disable iff (reset)
            (rsp_valid && !rsp_tmask[l]) |-> (rsp_data[l] == '0))
            else $error("inactive lane %0d returned data", l);
    end

endmodule

bind tex_mem_top tex_mem_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_tmask (rsp_tmask),
    .rsp_data  (rsp_data),
    .rsp_info  (rsp_info)
);

`default_nettype wire

//--- verification/tex_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tex_mem_tb;
    import tex_cfg_pkg::*;

    localparam int NUM_REQS       = 200;
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 40 + BANK_WORDS + RESET_CYCLES;

    typedef logic [NUM_LANES-1:0][NUM_TEXELS-1:0][DATA_W-1:0] quad_data_t;

    logic                                          clk;
    logic                                          reset;
    logic                                          load_valid;
    logic [BANK_AW-1:0]                            load_addr;
    logic [DATA_W-1:0]                             load_data;
    logic                                          req_valid;
    logic                                          req_ready;
    logic [NUM_LANES-1:0]                          req_tmask;
    logic                                          req_filter;
    logic [LGSTRIDE_W-1:0]                         req_lgstride;
    logic [NUM_LANES-1:0][ADDR_W-1:0]              req_baseaddr;
    logic [NUM_LANES-1:0][NUM_TEXELS-1:0][ADDR_W-1:0] req_addr;
    logic [INFO_W-1:0]                             req_info;
    logic                                          rsp_valid;
    logic                                          rsp_ready;
    logic [NUM_LANES-1:0]                          rsp_tmask;
    quad_data_t                                    rsp_data;
    logic [INFO_W-1:0]                             rsp_info;

    logic [DATA_W-1:0]    shadow_mem [BANK_WORDS];
    quad_data_t           exp_data_q [$];
    logic [NUM_LANES-1:0] exp_tmask_q [$];
    logic [INFO_W-1:0]    exp_info_q [$];
    int                   error_count;
    int                   rsp_count;
    logic                 stress;
    logic                 drain;
    logic                 saw_full;

    tex_mem_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_tmask    (req_tmask),
        .req_filter   (req_filter),
        .req_lgstride (req_lgstride),
        .req_baseaddr (req_baseaddr),
        .req_addr     (req_addr),
        .req_info     (req_info),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_tmask    (rsp_tmask),
        .rsp_data     (rsp_data),
        .rsp_info     (rsp_info)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // little-endian word, texel realigned and zero-extended
    function automatic quad_data_t expected_texels(
        input logic [NUM_LANES-1:0]                          tmask,
        input logic                                          filter,
        input logic [LGSTRIDE_W-1:0]                         lgstride,
        input logic [NUM_LANES-1:0][ADDR_W-1:0]              base,
        input logic [NUM_LANES-1:0][NUM_TEXELS-1:0][ADDR_W-1:0] offs
    );
        quad_data_t        result;
        logic [ADDR_W-1:0] byte_addr;
        logic [DATA_W-1:0] word;
        result = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int t = 0; t < NUM_TEXELS; t++) begin
                if (tmask[l] && (filter || t == 0)) begin
                    byte_addr = base[l] + offs[l][t];
                    word = shadow_mem[byte_addr[BANK_AW+1:2]];
                    case (lgstride)
                        2'd0:    result[l][t] = (word >> (8 * byte_addr[1:0])) & 32'h0000_00ff;
                        2'd1:    result[l][t] = (word >> (16 * byte_addr[1])) & 32'h0000_ffff;
                        default: result[l][t] = word;
                    endcase
                end
            end
        end
        return result;
    endfunction

    task automatic check_equal(input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s mismatch, got %h expected %h",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic load_memory();
        logic [DATA_W-1:0] word;
        for (int a = 0; a < BANK_WORDS; a++) begin
            word = $urandom;
            shadow_mem[a] = word;
            load_valid <= 1'b1;
            load_addr  <= BANK_AW'(a);
            load_data  <= word;
            @(posedge clk);
        end
        load_valid <= 1'b0;
    endtask

    // shared_word puts every lane of a texel on one word, bytes differ
    task automatic send_request(input bit shared_word);
        logic [NUM_LANES-1:0]                          tmask;
        logic                                          filter;
        logic [LGSTRIDE_W-1:0]                         lgstride;
        logic [INFO_W-1:0]                             info;
        logic [NUM_LANES-1:0][ADDR_W-1:0]              base;
        logic [NUM_LANES-1:0][NUM_TEXELS-1:0][ADDR_W-1:0] offs;
        logic [NUM_TEXELS-1:0][5:0]                    word_off;
        logic [ADDR_W-1:0]                             common_base;
        logic                                          took;
        tmask       = NUM_LANES'($urandom);
        filter      = 1'($urandom);
        // byte, halfword and word sizes only
        lgstride    = LGSTRIDE_W'($urandom_range(2, 0));
        info        = INFO_W'($urandom);
        common_base = $urandom & 32'hffff_fffc;
        for (int t = 0; t < NUM_TEXELS; t++) begin
            word_off[t] = 6'($urandom);
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            base[l] = shared_word ? common_base : ADDR_W'($urandom);
            for (int t = 0; t < NUM_TEXELS; t++) begin
                if (shared_word) begin
                    offs[l][t] = ADDR_W'({word_off[t], 2'b00}) + ADDR_W'($urandom_range(3, 0));
                end else begin
                    offs[l][t] = ADDR_W'($urandom_range(1023, 0));
                end
            end
        end
        req_valid    <= 1'b1;
        req_tmask    <= tmask;
        req_filter   <= filter;
        req_lgstride <= lgstride;
        req_baseaddr <= base;
        req_addr     <= offs;
        req_info     <= info;
        do begin
            @(negedge clk);
            took = req_ready;
            if (!took && stress) begin
                saw_full = 1'b1;
            end
            @(posedge clk);
        end while (!took);
        exp_data_q.push_back(expected_texels(tmask, filter, lgstride, base, offs));
        exp_tmask_q.push_back(tmask);
        exp_info_q.push_back(info);
    endtask

    initial begin
        void'($urandom(32'hf4ea8ec5));
        reset        = 1'b1;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        req_valid    = 1'b0;
        req_tmask    = '0;
        req_filter   = 1'b0;
        req_lgstride = '0;
        req_baseaddr = '0;
        req_addr     = '0;
        req_info     = '0;
        error_count  = 0;
        stress       = 1'b0;
        drain        = 1'b0;
        saw_full     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        load_memory();
        // back-to-back first, then under random back-pressure
        for (int n = 0; n < NUM_REQS; n++) begin
            if (n == NUM_REQS / 2) begin
                stress = 1'b1;
            end
            send_request($urandom_range(2, 0) == 0);
        end
        req_valid <= 1'b0;
        drain = 1'b1;
        wait (rsp_count == NUM_REQS);
        repeat (10) @(posedge clk);
        check_equal(DATA_W'(saw_full), 32'd1, "req_ready low during back-pressure");
        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "checks failed");
        end
    end

    // long low stretches on rsp_ready once stress starts
    initial begin
        int hold;
        rsp_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (stress && !drain) begin
                rsp_ready <= 1'b0;
                hold = $urandom_range(30, 5);
                repeat (hold) @(posedge clk);
                rsp_ready <= 1'b1;
                hold = $urandom_range(15, 1);
                repeat (hold) @(posedge clk);
            end else begin
                rsp_ready <= 1'b1;
            end
        end
    end

    initial begin
        quad_data_t           exp_data;
        logic [NUM_LANES-1:0] exp_tmask;
        logic [INFO_W-1:0]    exp_info;
        rsp_count = 0;
        forever begin
            @(negedge clk);
            if (!reset && rsp_valid && rsp_ready) begin
                check_equal(DATA_W'(exp_info_q.size() != 0), 32'd1,
                            "response with a pending request");
                exp_data  = exp_data_q.pop_front();
                exp_tmask = exp_tmask_q.pop_front();
                exp_info  = exp_info_q.pop_front();
                check_equal(DATA_W'(rsp_tmask), DATA_W'(exp_tmask), "rsp_tmask");
                check_equal(DATA_W'(rsp_info), DATA_W'(exp_info), "rsp_info");
                for (int l = 0; l < NUM_LANES; l++) begin
                    for (int t = 0; t < NUM_TEXELS; t++) begin
                        check_equal(rsp_data[l][t], exp_data[l][t],
                                    $sformatf("lane %0d texel %0d data", l, t));
                    end
                end
                rsp_count++;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: not all responses came back in time");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- tex_mem_top.f
common/tex_cfg_pkg.sv
common/tex_types_pkg.sv
common/tex_bank_req_if.sv
common/tex_bank_rsp_if.sv
src/tex_mem_bank.sv
tex_mem/tex_req_issue.sv
tex_mem/tex_rsp_merge.sv
src/tex_mem_top.sv
verification/tex_mem_assertions.sv
verification/tex_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tex_mem_top.f \
    --top-module tex_mem_tb -o tex_mem_sim &&
./obj_dir/tex_mem_sim | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
